// File: csa_multiplier.f
+incdir+.
mult_pkg.sv
csa_stage_if.sv
pp_generator.sv
csa_reduce_stage.sv
carry_prop_adder.sv
csa_multiplier.sv
tb_csa_multiplier.sv

// File: tb_csa_multiplier.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module tb_csa_multiplier import mult_pkg::*; ();

    localparam int LATENCY      = `MULT_LATENCY;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 10;
    localparam int CORNER_PAIRS = 39;
    localparam int BURST_LEN    = 64;
    localparam int GAP_LEN      = 80;
    localparam int DRAIN_CYCLES = LATENCY + 3;

    // reset, idle wait, all stimulus cycles, five drains and the in-flight reset sequence.
    localparam int TEST_CYCLES = RESET_CYCLES + IDLE_CYCLES + CORNER_PAIRS + BURST_LEN
                               + GAP_LEN + 5 * (LATENCY + 2) + 10;
    localparam int CYCLE_LIMIT = (TEST_CYCLES * 7) / 4;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    operand_t x;
    operand_t y;
    logic     out_valid;
    product_t product;

    product_t    exp_q [$];     // expected products in input order.
    int          due_q [$];     // edge at which each product must appear.
    int          cycle_cnt    = 0;
    bit          rst_at_edge  = 1'b1;
    logic [31:0] lcg_state    = 32'hffab_f7cf;

    csa_multiplier uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .x         (x),
        .y         (y),
        .out_valid (out_valid),
        .product   (product)
    );

    always #4 clk = ~clk;

    // ####################
    // helpers
    // ####################

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
                                     $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic operand_t rand_operand();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];   // upper bits have the longest period.
    endfunction

    task automatic send_pair(input operand_t a, input operand_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        x        <= a;
        y        <= b;
    endtask

    // idle cycle with junk operands that must never reach the output.
    task automatic send_idle();
        @(posedge clk);
        in_valid <= 1'b0;
        x        <= rand_operand();
        y        <= rand_operand();
    endtask

    task automatic drain_results(input string test_name);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (exp_q.size() != 0 && waited < DRAIN_CYCLES);
        if (exp_q.size() != 0) begin
            report_failure($sformatf("ERROR: %0d products still expected at the end of the %s test",
                                     exp_q.size(), test_name));
        end
    endtask

    // ####################
    // monitor and checker
    // ####################

    // inputs are taken as the DUT samples them, before the edge updates anything.
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            report_failure($sformatf("ERROR: timeout, the run passed %0d cycles", CYCLE_LIMIT));
        end
        if (rst_n !== 1'b1) begin
            rst_at_edge = 1'b1;
            exp_q.delete();   // pairs in flight are dropped by reset.
            due_q.delete();
        end else begin
            rst_at_edge = 1'b0;
            if (in_valid === 1'b1) begin
                exp_q.push_back(product_t'(x) * product_t'(y));
                due_q.push_back(cycle_cnt + LATENCY);
            end
        end
    end

    // outputs are stable half a cycle after the edge.
    always @(negedge clk) begin
        if (rst_at_edge && out_valid === 1'b1) begin
            report_failure("ERROR: out_valid is high right after a reset edge");
        end else if (!rst_at_edge && cycle_cnt > 0 && $isunknown(out_valid)) begin
            report_failure("ERROR: out_valid is unknown after reset");
        end else if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_failure("ERROR: out_valid is high but no product is expected");
            end else begin
                check_value("product", product, exp_q.pop_front());
                check_value("out_valid cycle", cycle_cnt, due_q.pop_front());
            end
        end else if (due_q.size() != 0 && cycle_cnt >= due_q[0]) begin
            report_failure($sformatf("ERROR: no product at cycle %0d for the input of cycle %0d",
                                     cycle_cnt, due_q[0] - LATENCY));
        end
    end

    // ####################
    // directed tests
    // ####################

    task automatic test_reset_idle();
        @(negedge clk);
        check_value("product", product, 32'h0);
        check_value("out_valid", out_valid, 32'h0);
        repeat (IDLE_CYCLES) begin
            send_idle();
            @(negedge clk);
            check_value("out_valid", out_valid, 32'h0);
        end
    endtask

    task automatic test_corners();
        send_pair(16'h0000, 16'h1234);
        send_pair(16'habcd, 16'h0000);
        send_pair(16'h0001, 16'hffff);
        send_pair(16'hffff, 16'h0001);
        send_pair(16'hffff, 16'hffff);   // 0xfffe0001.
        send_pair(16'he000, 16'h0100);
        send_pair(16'h0100, 16'he000);
        // one multiplier row live at a time.
        for (int i = 0; i < 16; i++) begin
            send_pair(16'hffff, operand_t'(1) << i);
            send_pair(operand_t'(1) << ((i * 7) % 16), operand_t'(1) << i);
        end
        send_idle();
        drain_results("corner");
    endtask

    task automatic test_burst();
        repeat (BURST_LEN) begin
            send_pair(rand_operand(), rand_operand());
        end
        send_idle();
        drain_results("burst");
    endtask

    task automatic test_gaps();
        logic [31:0] r;
        for (int i = 0; i < GAP_LEN; i++) begin
            r = lcg_next();
            if (r[20]) begin
                send_pair(rand_operand(), rand_operand());
            end else begin
                send_idle();
            end
        end
        send_idle();
        drain_results("gap");
    endtask

    task automatic test_reset_in_flight();
        repeat (3) begin
            send_pair(rand_operand(), rand_operand());
        end
        @(posedge clk);
        in_valid <= 1'b0;
        rst_n    <= 1'b0;
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (LATENCY + 1) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 32'h0);
        end
        send_pair(16'h1234, 16'h5678);
        send_idle();
        drain_results("reset in flight");
    endtask

    // ####################
    // run
    // ####################

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        x        = '0;
        y        = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_idle();
        test_corners();
        test_burst();
        test_gaps();
        test_reset_in_flight();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: csa_multiplier.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module csa_multiplier import mult_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  operand_t x,
    input  operand_t y,
    output logic     out_valid,
    output product_t product
);

    localparam int NUM_STAGES = `MULT_NUM_STAGES;

    // one slot after the producer and one after each reduction stage.
    csa_stage_if stage_if [NUM_STAGES+1] ();

    // ####################
    // pipeline chain
    // ####################

    pp_generator u_pp_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .x        (x),
        .y        (y),
        .slot     (stage_if[0])
    );

    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
        csa_reduce_stage #(
            .FIRST_ROW (2 + s * `MULT_STAGE_ROWS)
        ) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .up    (stage_if[s]),
            .down  (stage_if[s+1])
        );
    end

    carry_prop_adder u_cpa (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot      (stage_if[NUM_STAGES]),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

// File: carry_prop_adder.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module carry_prop_adder import mult_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    csa_stage_if.consumer slot,
    output logic          out_valid,
    output product_t      product
);

    localparam int W = `MULT_PROD_W;

    logic     [W:0] ripple;
    product_t       half_sum;
    product_t       sum_bits;

    // ####################
    // ripple adder
    // ####################

    always_comb begin
        ripple[0] = 1'b0;
        for (int i = 0; i < W; i++) begin
            half_sum[i]  = slot.sum_vec[i] ^ slot.carry_vec[i];
            sum_bits[i]  = half_sum[i] ^ ripple[i];
            ripple[i+1]  = (slot.sum_vec[i] & slot.carry_vec[i]) | (half_sum[i] & ripple[i]);
        end
    end

    // ####################
    // output register
    // ####################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            product   <= '0;
        end else begin
            out_valid <= slot.valid;
            if (slot.valid) begin
                product <= sum_bits;   // holds the last result while idle.
            end
        end
    end

    // a full 16x16 product always fits, so the top carry must stay clear.
    a_no_carry_out : assert property (
        @(posedge clk) disable iff (!rst_n)
        slot.valid |-> !ripple[W]
    ) else $error("carry_prop_adder: carry out of the top product bit");

endmodule

// File: csa_reduce_stage.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module csa_reduce_stage import mult_pkg::*; #(
    parameter int FIRST_ROW = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    csa_stage_if.consumer up,
    csa_stage_if.producer down
);

    localparam int ROWS = `MULT_STAGE_ROWS;
    localparam int MSB  = `MULT_PROD_W - 1;

    product_t            sum_chain   [ROWS+1];
    product_t            carry_chain [ROWS+1];
    product_t            pp          [ROWS];
    product_t            maj         [ROWS];
    logic     [ROWS-1:0] lost_carry;

    if (FIRST_ROW + ROWS > `MULT_OP_W) begin : g_bad_range
        $error("csa_reduce_stage: rows run past the multiplier width");
    end

    assign sum_chain[0]   = up.sum_vec;
    assign carry_chain[0] = up.carry_vec;

    // ####################
    // 3:2 compressor rows
    // ####################

    // one full-adder row per partial product, all columns at once.
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        assign pp[r] = pp_row(up.x_op, up.y_op[FIRST_ROW + r], FIRST_ROW + r);

        assign maj[r] = (sum_chain[r] & carry_chain[r])
                      | (sum_chain[r] & pp[r])
                      | (carry_chain[r] & pp[r]);   // column carries.

        assign sum_chain[r+1]   = sum_chain[r] ^ carry_chain[r] ^ pp[r];
        assign carry_chain[r+1] = maj[r] << 1;      // carries move up one column.
        assign lost_carry[r]    = maj[r][MSB];
    end

    // ####################
    // stage register
    // ####################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid) begin
            down.x_op      <= up.x_op;
            down.y_op      <= up.y_op;
            down.sum_vec   <= sum_chain[ROWS];
            down.carry_vec <= carry_chain[ROWS];
        end
    end

    // the pair must stay within the product width through every row of the chain.
    a_no_lost_carry : assert property (
        @(posedge clk) disable iff (!rst_n)
        up.valid |-> (lost_carry == '0)
    ) else $error("csa_reduce_stage: carry dropped past the product width");

endmodule

// File: pp_generator.sv
`timescale 1ns/1ps

module pp_generator import mult_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  operand_t      x,
    input  operand_t      y,
    csa_stage_if.producer slot
);

    product_t row0;
    product_t row1;

    // ####################
    // first two rows
    // ####################

    // two rows already form a carry-save pair, so no adder is needed here.
    assign row0 = pp_row(x, y[0], 0);
    assign row1 = pp_row(x, y[1], 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot.valid <= 1'b0;
        end else begin
            slot.valid <= in_valid;
        end
    end

    // operands are only taken on a live input. idle cycles leave the slot unchanged.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            slot.x_op      <= x;
            slot.y_op      <= y;
            slot.sum_vec   <= row0;
            slot.carry_vec <= row1;
        end
    end

    // in_valid comes from outside the design and must be driven once out of reset.
    a_valid_known : assert property (
        @(posedge clk) rst_n |-> !$isunknown(slot.valid)
    ) else $error("pp_generator: slot valid is unknown after reset");

endmodule

// File: csa_stage_if.sv
`timescale 1ns/1ps

interface csa_stage_if import mult_pkg::*; ();

    logic     valid;       // slot holds a live item.
    operand_t x_op;        // multiplicand carried down the chain.
    operand_t y_op;        // multiplier bits still to be used.
    product_t sum_vec;
    product_t carry_vec;   // already aligned to its column.

    modport producer (
        output valid,
        output x_op,
        output y_op,
        output sum_vec,
        output carry_vec
    );

    modport consumer (
        input valid,
        input x_op,
        input y_op,
        input sum_vec,
        input carry_vec
    );

endinterface

// File: mult_pkg.sv
`include "mult_consts.svh"

package mult_pkg;

    typedef logic [`MULT_OP_W-1:0]   operand_t;   // unsigned operand.
    typedef logic [`MULT_PROD_W-1:0] product_t;   // product or one carry-save vector.

    // ####################
    // partial products
    // ####################

    // AND of the whole multiplicand with one multiplier bit, moved to its column.
    function automatic product_t pp_row(
        input operand_t    x,
        input logic        y_bit,
        input int unsigned shift
    );
        product_t row;
        row = product_t'(x & {`MULT_OP_W{y_bit}});
        return row << shift;
    endfunction

endpackage

// File: mult_consts.svh
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// ####################
// datapath widths
// ####################

`define MULT_OP_W       16
`define MULT_PROD_W     32

// ####################
// pipeline shape
// ####################

// rows beyond the first two are spread evenly over the reduction stages.
`define MULT_STAGE_ROWS 7
`define MULT_NUM_STAGES ((`MULT_OP_W - 2) / `MULT_STAGE_ROWS)

// producer register plus one register per reduction stage.
`define MULT_LATENCY    (`MULT_NUM_STAGES + 1)

`endif
